// ==== include/udp_echo_cfg.svh ====
// ==========================================================================
// Build-time sizes and register reset values for the UDP echo core
// FIFO depths must be at least 1; other values are loaded on reset
// ==========================================================================
`ifndef UDP_ECHO_CFG_SVH
`define UDP_ECHO_CFG_SVH

// Reply headers held between steering and the tx header port
`define ECHO_HDR_FIFO_DEPTH 4

// Payload beats held between steering and the tx payload port
`define ECHO_PAYLOAD_FIFO_DEPTH 64

// 192.168.0.3
`define ECHO_DEFAULT_LOCAL_IP 32'hC0A8_0003

// Listen port after reset
`define ECHO_DEFAULT_PORT 16'd1234

// TTL placed in every reply
`define ECHO_DEFAULT_TTL 8'd64

`endif

// ==== logic/udp_pkg.sv ====
// ==========================================================================
// UDP and IPv4 field types shared by the echo data path
// Checksum, DSCP and ECN fields are not carried
// ==========================================================================
package udp_pkg;

    typedef logic [31:0] ip_addr_t;

    typedef logic [15:0] udp_port_t;

    // UDP length covers header plus payload, in bytes
    typedef logic [15:0] udp_len_t;

    typedef logic [7:0] ttl_t;

    // Reply header, 120 bits
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
        ttl_t      ttl;
    } reply_hdr_t;

    // One payload byte with its frame markers
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } payload_beat_t;

endpackage

// ==== logic/echo_regs_pkg.sv ====
// ==========================================================================
// Register map of the echo configuration block
// Registers are write-only and take the low bits of the write data
// ==========================================================================
package echo_regs_pkg;

    typedef enum logic [1:0] {
        REG_LOCAL_IP    = 2'd0,
        REG_LISTEN_PORT = 2'd1,
        REG_TTL         = 2'd2,
        REG_ENABLE      = 2'd3
    } cfg_addr_t;

    // Field widths, all starting at bit 0 of the write data
    localparam int unsigned LOCAL_IP_W    = 32;
    localparam int unsigned LISTEN_PORT_W = 16;
    localparam int unsigned TTL_W         = 8;
    localparam int unsigned ENABLE_W      = 1;

endpackage

// ==== logic/echo_cfg_if.sv ====
// ==========================================================================
// Configuration bundle from the register block to the steering logic
// Values are static between writes, no handshake
// ==========================================================================
`timescale 1ns/1ns

interface echo_cfg_if;

    udp_pkg::ip_addr_t  local_ip;
    udp_pkg::udp_port_t listen_port;
    udp_pkg::ttl_t      ttl;
    logic               echo_enable;

    // Register side
    modport regs (
        output local_ip,
        output listen_port,
        output ttl,
        output echo_enable
    );

    // Consumer side
    modport user (
        input local_ip,
        input listen_port,
        input ttl,
        input echo_enable
    );

endinterface

// ==== logic/echo_cfg_regs.sv ====
// ==========================================================================
// Write-only configuration registers, new value visible the cycle after
// the write; there is no readback path
// ==========================================================================
`timescale 1ns/1ns
`include "udp_echo_cfg.svh"

module echo_cfg_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_we,
    input  echo_regs_pkg::cfg_addr_t cfg_addr,
    input  logic [31:0]             cfg_wdata,
    echo_cfg_if.regs                cfg
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.local_ip    <= `ECHO_DEFAULT_LOCAL_IP;
            cfg.listen_port <= `ECHO_DEFAULT_PORT;
            cfg.ttl         <= `ECHO_DEFAULT_TTL;
            // Echo is on out of reset
            cfg.echo_enable <= 1'b1;
        end else if (cfg_we) begin
            case (cfg_addr)
                echo_regs_pkg::REG_LOCAL_IP: begin
                    cfg.local_ip <= cfg_wdata[echo_regs_pkg::LOCAL_IP_W-1:0];
                end
                echo_regs_pkg::REG_LISTEN_PORT: begin
                    cfg.listen_port <= cfg_wdata[echo_regs_pkg::LISTEN_PORT_W-1:0];
                end
                echo_regs_pkg::REG_TTL: begin
                    cfg.ttl <= cfg_wdata[echo_regs_pkg::TTL_W-1:0];
                end
                echo_regs_pkg::REG_ENABLE: begin
                    cfg.echo_enable <= cfg_wdata[echo_regs_pkg::ENABLE_W-1];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== logic/echo_steer.sv ====
// ==========================================================================
// Per-datagram match decision and payload steering
// Expects each header before its payload and exactly one last beat per frame
// ==========================================================================
`timescale 1ns/1ns

module echo_steer (
    input  logic                  clk,
    input  logic                  rst,
    echo_cfg_if.user              cfg,

    input  logic                  rx_hdr_valid,
    output logic                  rx_hdr_ready,
    input  udp_pkg::ip_addr_t     rx_src_ip,
    input  udp_pkg::udp_port_t    rx_src_port,
    input  udp_pkg::udp_port_t    rx_dst_port,
    input  udp_pkg::udp_len_t     rx_udp_length,

    input  logic                  rx_valid,
    output logic                  rx_ready,
    input  udp_pkg::payload_beat_t rx_beat,

    output logic                  hdr_valid,
    input  logic                  hdr_ready,
    output udp_pkg::reply_hdr_t   hdr,

    output logic                  beat_valid,
    input  logic                  beat_ready,
    output udp_pkg::payload_beat_t beat
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t state;
    logic   match;
    logic   match_reg;
    logic   hdr_fire;
    logic   last_fire;

    assign match = cfg.echo_enable && (rx_dst_port == cfg.listen_port);

    // A matching header waits for room in the header FIFO, others go at once
    assign rx_hdr_ready = (state == ST_IDLE) && (!match || hdr_ready);
    assign hdr_valid    = (state == ST_IDLE) && rx_hdr_valid && match;
    assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;

    // Reply goes back where it came from
    assign hdr.src_ip   = cfg.local_ip;
    assign hdr.dst_ip   = rx_src_ip;
    assign hdr.src_port = rx_dst_port;
    assign hdr.dst_port = rx_src_port;
    assign hdr.length   = rx_udp_length;
    assign hdr.ttl      = cfg.ttl;

    // Dropped payload is sunk at full rate
    assign rx_ready   = (state == ST_BUSY) && (!match_reg || beat_ready);
    assign beat_valid = (state == ST_BUSY) && match_reg && rx_valid;
    assign beat       = rx_beat;
    assign last_fire  = rx_valid && rx_ready && rx_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            match_reg <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        match_reg <= match;
                        state     <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (last_fire) begin
                        match_reg <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/stream_fifo.sv ====
// ==========================================================================
// Valid/ready FIFO for any packed item type, no bypass path
// An item is offered the cycle after it is written
// ==========================================================================
`timescale 1ns/1ns

module stream_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    output logic  in_ready,
    input  item_t in_item,
    output logic  out_valid,
    input  logic  out_ready,
    output item_t out_item
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Wrap also works for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    // Output comes straight from storage flops
    assign out_item  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/led_capture.sv ====
// ==========================================================================
// Shows the first byte of each outgoing frame on the LEDs
// ==========================================================================
`timescale 1ns/1ns

module led_capture (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tx_valid,
    input  logic                   tx_ready,
    input  udp_pkg::payload_beat_t tx_beat,
    output logic [7:0]             led
);

    logic first_beat;
    logic tx_fire;

    assign tx_fire = tx_valid && tx_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= 8'h00;
        end else if (tx_fire) begin
            if (first_beat) begin
                led <= tx_beat.data;
            end
            // Next beat opens a new frame only after a last
            first_beat <= tx_beat.last;
        end
    end

endmodule

// ==== logic/udp_echo_core.sv ====
// ==========================================================================
// UDP echo core, replies to datagrams sent to the listen port
// Header and payload must come from an IP stack already split apart
// ==========================================================================
`timescale 1ns/1ns
`include "udp_echo_cfg.svh"

module udp_echo_core (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     cfg_we,
    input  echo_regs_pkg::cfg_addr_t cfg_addr,
    input  logic [31:0]              cfg_wdata,

    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_pkg::ip_addr_t        rx_src_ip,
    input  udp_pkg::udp_port_t       rx_src_port,
    input  udp_pkg::udp_port_t       rx_dst_port,
    input  udp_pkg::udp_len_t        rx_udp_length,

    input  logic [7:0]               rx_data,
    input  logic                     rx_last,
    input  logic                     rx_user,
    input  logic                     rx_valid,
    output logic                     rx_ready,

    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_pkg::ip_addr_t        tx_src_ip,
    output udp_pkg::ip_addr_t        tx_dst_ip,
    output udp_pkg::udp_port_t       tx_src_port,
    output udp_pkg::udp_port_t       tx_dst_port,
    output udp_pkg::udp_len_t        tx_udp_length,
    output udp_pkg::ttl_t            tx_ttl,

    output logic [7:0]               tx_data,
    output logic                     tx_last,
    output logic                     tx_user,
    output logic                     tx_valid,
    input  logic                     tx_ready,

    output logic [7:0]               led
);

    echo_cfg_if cfg_bus ();

    udp_pkg::payload_beat_t rx_beat;
    udp_pkg::payload_beat_t steer_beat;
    udp_pkg::payload_beat_t tx_beat;
    udp_pkg::reply_hdr_t    steer_hdr;
    udp_pkg::reply_hdr_t    tx_hdr;
    logic                   steer_hdr_valid;
    logic                   steer_hdr_ready;
    logic                   steer_beat_valid;
    logic                   steer_beat_ready;

    assign rx_beat.data = rx_data;
    assign rx_beat.last = rx_last;
    assign rx_beat.user = rx_user;

    echo_cfg_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg_bus.regs)
    );

    echo_steer u_steer (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg_bus.user),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_src_ip     (rx_src_ip),
        .rx_src_port   (rx_src_port),
        .rx_dst_port   (rx_dst_port),
        .rx_udp_length (rx_udp_length),
        .rx_valid      (rx_valid),
        .rx_ready      (rx_ready),
        .rx_beat       (rx_beat),
        .hdr_valid     (steer_hdr_valid),
        .hdr_ready     (steer_hdr_ready),
        .hdr           (steer_hdr),
        .beat_valid    (steer_beat_valid),
        .beat_ready    (steer_beat_ready),
        .beat          (steer_beat)
    );

    // Several reply headers may queue ahead of their payloads
    stream_fifo #(
        .item_t (udp_pkg::reply_hdr_t),
        .DEPTH  (`ECHO_HDR_FIFO_DEPTH)
    ) u_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (steer_hdr_valid),
        .in_ready  (steer_hdr_ready),
        .in_item   (steer_hdr),
        .out_valid (tx_hdr_valid),
        .out_ready (tx_hdr_ready),
        .out_item  (tx_hdr)
    );

    stream_fifo #(
        .item_t (udp_pkg::payload_beat_t),
        .DEPTH  (`ECHO_PAYLOAD_FIFO_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (steer_beat_valid),
        .in_ready  (steer_beat_ready),
        .in_item   (steer_beat),
        .out_valid (tx_valid),
        .out_ready (tx_ready),
        .out_item  (tx_beat)
    );

    led_capture u_led (
        .clk      (clk),
        .rst      (rst),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_beat  (tx_beat),
        .led      (led)
    );

    assign tx_src_ip     = tx_hdr.src_ip;
    assign tx_dst_ip     = tx_hdr.dst_ip;
    assign tx_src_port   = tx_hdr.src_port;
    assign tx_dst_port   = tx_hdr.dst_port;
    assign tx_udp_length = tx_hdr.length;
    assign tx_ttl        = tx_hdr.ttl;

    assign tx_data = tx_beat.data;
    assign tx_last = tx_beat.last;
    assign tx_user = tx_beat.user;

endmodule

// ==== verification/udp_echo_core_sva.sv ====
// ==========================================================================
// Handshake checks on the tx ports of the echo core, bound to its top level
// ==========================================================================
`timescale 1ns/1ns

module udp_echo_core_sva (
    input logic               clk,
    input logic               rst,
    input logic               tx_valid,
    input logic               tx_ready,
    input logic [7:0]         tx_data,
    input logic               tx_last,
    input logic               tx_user,
    input logic               tx_hdr_valid,
    input logic               tx_hdr_ready,
    input udp_pkg::ip_addr_t  tx_src_ip,
    input udp_pkg::ip_addr_t  tx_dst_ip,
    input udp_pkg::udp_port_t tx_src_port,
    input udp_pkg::udp_port_t tx_dst_port,
    input udp_pkg::udp_len_t  tx_udp_length,
    input udp_pkg::ttl_t      tx_ttl
);

    // FIFOs are empty once the first reset edge has passed
    a_idle_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !tx_valid && !tx_hdr_valid)
        else $error("tx valid asserted during reset");

    a_payload_stable: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable({tx_data, tx_last, tx_user}))
        else $error("tx payload changed while stalled");

    a_hdr_stable: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable({tx_src_ip, tx_dst_ip,
        tx_src_port, tx_dst_port, tx_udp_length, tx_ttl}))
        else $error("tx header changed while stalled");

endmodule

bind udp_echo_core udp_echo_core_sva u_sva (
    .clk           (clk),
    .rst           (rst),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .tx_data       (tx_data),
    .tx_last       (tx_last),
    .tx_user       (tx_user),
    .tx_hdr_valid  (tx_hdr_valid),
    .tx_hdr_ready  (tx_hdr_ready),
    .tx_src_ip     (tx_src_ip),
    .tx_dst_ip     (tx_dst_ip),
    .tx_src_port   (tx_src_port),
    .tx_dst_port   (tx_dst_port),
    .tx_udp_length (tx_udp_length),
    .tx_ttl        (tx_ttl)
);

// ==== verification/udp_echo_core_tb.sv ====
// ==========================================================================
// Directed tests for the UDP echo core; payload sizes stay below the FIFO
// depth so a whole datagram can be sent before its echo is collected
// ==========================================================================
`timescale 1ns/1ns

module udp_echo_core_tb;

    localparam int TIMEOUT = 2000;

    logic clk, rst, cfg_we;
    echo_regs_pkg::cfg_addr_t cfg_addr;
    logic [31:0] cfg_wdata;
    logic rx_hdr_valid, rx_hdr_ready, rx_valid, rx_ready, rx_last, rx_user;
    udp_pkg::ip_addr_t  rx_src_ip, tx_src_ip, tx_dst_ip;
    udp_pkg::udp_port_t rx_src_port, rx_dst_port, tx_src_port, tx_dst_port;
    udp_pkg::udp_len_t  rx_udp_length, tx_udp_length;
    udp_pkg::ttl_t      tx_ttl;
    logic [7:0] rx_data, tx_data, led;
    logic tx_hdr_valid, tx_hdr_ready, tx_valid, tx_ready, tx_last, tx_user;

    // Expected register contents
    udp_pkg::ip_addr_t  model_ip;
    udp_pkg::udp_port_t model_port;
    udp_pkg::ttl_t      model_ttl;
    logic               model_en;

    udp_pkg::reply_hdr_t    exp_hdr_q[$];
    udp_pkg::payload_beat_t exp_beat_q[$];
    int                     exp_len_q[$];

    udp_echo_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic write_reg(input echo_regs_pkg::cfg_addr_t addr, input logic [31:0] data);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
        case (addr)
            echo_regs_pkg::REG_LOCAL_IP:    model_ip = data;
            echo_regs_pkg::REG_LISTEN_PORT: model_port = data[15:0];
            echo_regs_pkg::REG_TTL:         model_ttl = data[7:0];
            default:                        model_en = data[0];
        endcase
    endtask

    // Drives one datagram and records the echo it should cause
    task automatic send_datagram(input udp_pkg::ip_addr_t src_ip, input udp_pkg::udp_port_t sport,
                                 input udp_pkg::udp_port_t dport, input int nbytes);
        udp_pkg::reply_hdr_t    h;
        udp_pkg::payload_beat_t b;
        logic                   matched;
        int                     waited;
        matched    = model_en && (dport == model_port);
        h.src_ip   = model_ip;
        h.dst_ip   = src_ip;
        h.src_port = dport;
        h.dst_port = sport;
        h.length   = 16'(8 + nbytes);
        h.ttl      = model_ttl;
        if (matched) begin
            exp_hdr_q.push_back(h);
            exp_len_q.push_back(nbytes);
        end
        rx_src_ip     <= src_ip;
        rx_src_port   <= sport;
        rx_dst_port   <= dport;
        rx_udp_length <= h.length;
        rx_hdr_valid  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            assert (waited <= TIMEOUT) else abort_run("Timed out waiting for rx_hdr_ready");
        end while (!rx_hdr_ready);
        rx_hdr_valid <= 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            b.data = 8'($urandom);
            b.user = 1'($urandom);
            b.last = (i == nbytes - 1);
            if (matched) begin
                exp_beat_q.push_back(b);
            end
            rx_data  <= b.data;
            rx_last  <= b.last;
            rx_user  <= b.user;
            rx_valid <= 1'b1;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                assert (waited <= TIMEOUT) else abort_run("Timed out waiting for rx_ready");
            end while (!rx_ready);
        end
        rx_valid <= 1'b0;
    endtask

    // Collects the oldest expected echo, then checks the LEDs
    task automatic recv_frame();
        udp_pkg::reply_hdr_t    h;
        udp_pkg::payload_beat_t b;
        logic [7:0]             first;
        int                     n;
        int                     waited;
        assert (exp_hdr_q.size() > 0) else abort_run("No echo expected but one was requested");
        h = exp_hdr_q.pop_front();
        n = exp_len_q.pop_front();
        first = 8'h00;
        tx_hdr_ready <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            assert (waited <= TIMEOUT) else abort_run("Timed out waiting for tx_hdr_valid");
        end while (!tx_hdr_valid);
        tx_hdr_ready <= 1'b0;
        check_value("tx_src_ip", tx_src_ip, h.src_ip);
        check_value("tx_dst_ip", tx_dst_ip, h.dst_ip);
        check_value("tx_src_port", 32'(tx_src_port), 32'(h.src_port));
        check_value("tx_dst_port", 32'(tx_dst_port), 32'(h.dst_port));
        check_value("tx_udp_length", 32'(tx_udp_length), 32'(h.length));
        check_value("tx_ttl", 32'(tx_ttl), 32'(h.ttl));
        tx_ready <= 1'b1;
        for (int i = 0; i < n; i++) begin
            b = exp_beat_q.pop_front();
            if (i == 0) begin
                first = b.data;
            end
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                assert (waited <= TIMEOUT) else abort_run("Timed out waiting for tx_valid");
            end while (!tx_valid);
            check_value("tx_data", 32'(tx_data), 32'(b.data));
            check_value("tx_last", 32'(tx_last), 32'(b.last));
            check_value("tx_user", 32'(tx_user), 32'(b.user));
        end
        tx_ready <= 1'b0;
        @(posedge clk);
        check_value("led", 32'(led), 32'(first));
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            assert (!tx_hdr_valid && !tx_valid) else abort_run("Dropped datagram produced tx output");
        end
    endtask

    task automatic test_reset_state();
        check_value("led", 32'(led), 32'h0);
        check_value("tx_valid", 32'(tx_valid), 32'h0);
        check_value("tx_hdr_valid", 32'(tx_hdr_valid), 32'h0);
        send_datagram(32'h0A00_0007, 16'd5000, 16'd1234, 6);
        recv_frame();
    endtask

    task automatic test_echo();
        send_datagram(32'hAC10_0105, 16'd40000, 16'd1234, 1);
        recv_frame();
        send_datagram(32'h0102_0304, 16'd53, 16'd1234, 17);
        recv_frame();
    endtask

    task automatic test_filter();
        send_datagram(32'h0A00_0008, 16'd6000, 16'd80, 7);
        expect_silence(200);
        send_datagram(32'h0A00_0009, 16'd6001, 16'd1234, 4);
        recv_frame();
    endtask

    task automatic test_config();
        // Upper bits of the port and TTL writes must be ignored
        write_reg(echo_regs_pkg::REG_LOCAL_IP, 32'h0A00_0042);
        write_reg(echo_regs_pkg::REG_LISTEN_PORT, 32'hABCD_1E61);
        write_reg(echo_regs_pkg::REG_TTL, 32'h1234_5611);
        send_datagram(32'hC0A8_0010, 16'd9000, 16'd7777, 5);
        recv_frame();
        send_datagram(32'hC0A8_0011, 16'd9001, 16'd1234, 5);
        expect_silence(200);
        write_reg(echo_regs_pkg::REG_ENABLE, 32'h0);
        send_datagram(32'hC0A8_0012, 16'd9002, 16'd7777, 5);
        expect_silence(200);
        write_reg(echo_regs_pkg::REG_ENABLE, 32'h1);
    endtask

    task automatic test_backpressure();
        send_datagram(32'h0B00_0001, 16'd100, 16'd7777, 5);
        send_datagram(32'h0B00_0002, 16'd101, 16'd7777, 9);
        send_datagram(32'h0B00_0003, 16'd102, 16'd7777, 3);
        repeat (3) begin
            recv_frame();
        end
    endtask

    initial begin
        void'($urandom(78259));
        rst           <= 1'b1;
        cfg_we        <= 1'b0;
        cfg_addr      <= echo_regs_pkg::REG_LOCAL_IP;
        cfg_wdata     <= 32'h0;
        rx_hdr_valid  <= 1'b0;
        rx_src_ip     <= 32'h0;
        rx_src_port   <= 16'h0;
        rx_dst_port   <= 16'h0;
        rx_udp_length <= 16'h0;
        rx_data       <= 8'h00;
        rx_last       <= 1'b0;
        rx_user       <= 1'b0;
        rx_valid      <= 1'b0;
        tx_hdr_ready  <= 1'b0;
        tx_ready      <= 1'b0;
        // 192.168.0.3, port 1234, TTL 64, echo on
        model_ip   = 32'hC0A8_0003;
        model_port = 16'd1234;
        model_ttl  = 8'd64;
        model_en   = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_echo();
        test_filter();
        test_config();
        test_backpressure();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== udp_echo_core.f ====
+incdir+include
logic/udp_pkg.sv
logic/echo_regs_pkg.sv
logic/echo_cfg_if.sv
logic/echo_cfg_regs.sv
logic/echo_steer.sv
logic/stream_fifo.sv
logic/led_capture.sv
logic/udp_echo_core.sv
verification/udp_echo_core_sva.sv
verification/udp_echo_core_tb.sv

// ==== Makefile ====
TOP = udp_echo_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f udp_echo_core.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
